// File: hw/ifu_pkg.sv
/*
	Shared definitions for the instruction fetch unit.
	Holds the cache geometry, the pc field positions and the line, tag
	and way types. RTL modules pull it in by a wildcard import in their
	module header.
*/

package ifu_pkg;

	localparam int addr_w = 64; // pc and AXI address
	localparam int line_w = 256; // One cache line and one AXI data beat
	localparam int instr_w = 64; // One fetched doubleword

	localparam int num_ways = 2;
	localparam int way_idx_w = $clog2(num_ways);

	localparam int idx_w = 6; // Set index from pc[10:5]
	localparam int num_sets = 1 << idx_w;
	localparam int off_w = 5; // Byte offset in a line
	localparam int dw_sel_w = 2; // Doubleword select from pc[4:3]
	localparam int tag_w = 21; // Tag from pc[31:11] so upper bits are not compared

	localparam logic [2:0] arprot_fetch = 3'b001; // ARPROT on every fetch read

	// The replacement LFSR must never start at zero
	localparam int lfsr_w = 8;
	localparam logic [lfsr_w-1:0] lfsr_seed = 8'hb5;

	typedef logic [line_w-1:0] line_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [num_ways-1:0] way_t; // One-hot way select

endpackage

// File: hw/gen_sram.sv
/*
	Synchronous memory with one write port and one read port.
	Read data is registered on a cycle with en_r high and held otherwise.
	The entry type is a type parameter, so the same block stores tags
	and whole cache lines.
*/

`timescale 1ns/1ps

module gen_sram import ifu_pkg::*; #(
	parameter type entry_t = logic
) (
	input logic CLK,

	input logic en_w,
	input logic [idx_w-1:0] addr_w,
	input entry_t data_w,

	input logic en_r,
	input logic [idx_w-1:0] addr_r,
	output entry_t data_r
);

	entry_t mem [num_sets];

	always_ff @(posedge CLK) begin
		if (en_w) begin
			mem[addr_w] <= data_w;
		end
	end

	always_ff @(posedge CLK) begin
		if (en_r) begin
			data_r <= mem[addr_r]; // Old contents on a same-address write
		end
	end

endmodule

// File: hw/icache_victim.sv
/*
	Refill way selection for the instruction cache.
	Takes the valid bits of the set being refilled and returns a one-hot
	way. An empty way wins, lowest first; with every way full a free
	running LFSR picks one.
*/

`timescale 1ns/1ps

module icache_victim import ifu_pkg::*; (
	input logic CLK,
	input logic rst,
	input way_t set_valid,
	output way_t victim
);

	logic [lfsr_w-1:0] lfsr;
	logic lfsr_fb;
	way_t free_way;

	// Maximal length polynomial x^8 + x^6 + x^5 + x^4 + 1
	assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	always_ff @(posedge CLK) begin
		if (rst) begin
			lfsr <= lfsr_seed;
		end else begin
			lfsr <= {lfsr[lfsr_w-2:0], lfsr_fb}; // Steps every cycle
		end
	end

	always_comb begin
		free_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!set_valid[w]) free_way = way_t'(1) << w; // Last hit is the lowest
		end
	end

	assign victim = (&set_valid) ? (way_t'(1) << lfsr[way_idx_w-1:0]) : free_way;

endmodule

// File: hw/icache_array.sv
/*
	Storage and lookup for the 2-way instruction cache.
	A lookup_en pulse reads tags and lines of the set at lookup_addr;
	one cycle later hit or miss is pulsed, with the hitting line on
	hit_line. A refill writes tag, line and valid bit of the victim way
	at the same held index. invalidate clears all valid bits at once.
*/

`timescale 1ns/1ps

module icache_array import ifu_pkg::*; (
	input logic CLK,
	input logic rst,

	input logic lookup_en,
	input logic [addr_w-1:0] lookup_addr,
	input logic invalidate,

	output logic hit,
	output logic miss,
	output line_t hit_line,

	input logic refill_en,
	input line_t refill_line
);

	logic [idx_w-1:0] idx;
	tag_t lookup_tag;
	logic lookup_q; // Tag and line reads are valid this cycle

	way_t valid_q [num_sets];
	way_t cur_valid;
	way_t victim;
	way_t way_hit;

	tag_t tag_rd [num_ways];
	line_t line_rd [num_ways];

	assign idx = lookup_addr[off_w +: idx_w];
	assign lookup_tag = lookup_addr[off_w + idx_w +: tag_w];
	assign cur_valid = valid_q[idx]; // Index is held through lookup and refill

	for (genvar w = 0; w < num_ways; w++) begin : g_way
		gen_sram #(
			.entry_t(tag_t)
		) tag_ram (
			.CLK(CLK),
			.en_w(refill_en & victim[w]),
			.addr_w(idx),
			.data_w(lookup_tag),
			.en_r(lookup_en),
			.addr_r(idx),
			.data_r(tag_rd[w])
		);

		gen_sram #(
			.entry_t(line_t)
		) line_ram (
			.CLK(CLK),
			.en_w(refill_en & victim[w]),
			.addr_w(idx),
			.data_w(refill_line),
			.en_r(lookup_en),
			.addr_r(idx),
			.data_r(line_rd[w])
		);

		assign way_hit[w] = cur_valid[w] & (tag_rd[w] == lookup_tag);
	end

	icache_victim victim_i (
		.CLK(CLK),
		.rst(rst),
		.set_valid(cur_valid),
		.victim(victim)
	);

	always_ff @(posedge CLK) begin
		if (rst) begin
			lookup_q <= 1'b0;
		end else begin
			lookup_q <= lookup_en;
		end
	end

	// Invalidate wins over a refill in the same cycle
	always_ff @(posedge CLK) begin
		if (rst || invalidate) begin
			for (int s = 0; s < num_sets; s++) begin
				valid_q[s] <= '0;
			end
		end else if (refill_en) begin
			valid_q[idx] <= cur_valid | victim;
		end
	end

	assign hit = lookup_q & (|way_hit);
	assign miss = lookup_q & ~(|way_hit);

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (way_hit[w]) hit_line = line_rd[w];
		end
	end

	// A line is never held in both ways of a set
	a_way_hit_onehot: assert property (@(posedge CLK) disable iff (rst)
		lookup_q |-> $onehot0(way_hit));

endmodule

// File: hw/fetch_req.sv
/*
	Input side of the fetch unit.
	Takes fetch_addr from the pc generator on every edge with fetch_ready
	high, registers it as lookup_addr and pulses lookup_en one cycle
	later. Only one fetch is in flight; done or flush ends it.
*/

`timescale 1ns/1ps

module fetch_req import ifu_pkg::*; (
	input logic CLK,
	input logic rst,

	input logic [addr_w-1:0] fetch_addr,
	output logic fetch_ready,
	input logic flush,

	input logic out_busy, // Output stage full and not draining
	input logic stale_pending,
	input logic done, // Hit or refill

	output logic lookup_en,
	output logic [addr_w-1:0] lookup_addr
);

	logic busy;

	assign fetch_ready = ~busy & ~out_busy & ~stale_pending & ~flush;

	always_ff @(posedge CLK) begin
		if (rst) begin
			busy <= 1'b0;
			lookup_en <= 1'b0;
		end else begin
			lookup_en <= fetch_ready;
			if (fetch_ready) begin
				busy <= 1'b1; // New request wins over a late done
			end else if (done || flush) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch_ready) begin
			lookup_addr <= fetch_addr;
		end
	end

endmodule

// File: hw/miss_axi_master.sv
/*
	AXI read master for instruction cache misses.
	A miss raises ARVALID with the line-aligned address and keeps RREADY
	high until the single 256-bit beat returns. The beat becomes a
	refill_en pulse, unless a flush arrived while the read was out, in
	which case it is taken and dropped. A miss that is flushed in its
	own cycle or the cycle before issues no read at all.
*/

`timescale 1ns/1ps

module miss_axi_master import ifu_pkg::*; (
	input logic CLK,
	input logic rst,

	input logic miss,
	input logic [addr_w-1:0] miss_addr,
	input logic flush,

	output logic arvalid,
	output logic [addr_w-1:0] araddr,
	output logic [2:0] arprot,
	input logic arready,

	input logic rvalid,
	output logic rready,
	input line_t rdata,

	output logic refill_en,
	output line_t refill_line,
	output logic stale_pending
);

	logic outstanding; // From miss to R beat
	logic stale;
	logic flush_q;
	logic start;
	logic beat;
	logic stale_done;

	assign start = miss & ~flush & ~flush_q; // Lookup was squashed otherwise
	assign beat = rvalid & outstanding;
	assign stale_done = beat & stale;

	assign araddr = {miss_addr[addr_w-1:off_w], {off_w{1'b0}}}; // miss_addr is held
	assign arprot = arprot_fetch;
	assign rready = outstanding;

	assign refill_en = beat & ~stale;
	assign refill_line = rdata;
	assign stale_pending = stale;

	always_ff @(posedge CLK) begin
		if (rst) begin
			arvalid <= 1'b0;
			outstanding <= 1'b0;
			stale <= 1'b0;
			flush_q <= 1'b0;
		end else begin
			flush_q <= flush;

			if (start) begin
				arvalid <= 1'b1;
			end else if (arready) begin
				arvalid <= 1'b0;
			end

			if (start) begin
				outstanding <= 1'b1;
			end else if (beat) begin
				outstanding <= 1'b0;
			end

			if (stale_done) begin
				stale <= 1'b0;
			end else if (flush && outstanding && !beat) begin
				stale <= 1'b1; // Drop the beat when it comes back
			end
		end
	end

	a_ar_stable: assert property (@(posedge CLK) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// Data may only come back once the address handshake is done
	a_refill_outstanding: assert property (@(posedge CLK) disable iff (rst)
		refill_en |-> outstanding && !arvalid);

endmodule

// File: hw/iq_out_stage.sv
/*
	Output side of the fetch unit.
	Picks doubleword pc[4:3] from the hit line or the refill line and
	registers it with its pc toward the instruction queue. The entry is
	held until if_iq_ready and dropped on flush. A result from a lookup
	flushed one cycle earlier is ignored.
*/

`timescale 1ns/1ps

module iq_out_stage import ifu_pkg::*; (
	input logic CLK,
	input logic rst,

	input logic hit,
	input line_t hit_line,
	input logic refill_en,
	input line_t refill_line,
	input logic [addr_w-1:0] lookup_addr,
	input logic flush,

	output logic out_busy,

	output logic [addr_w-1:0] if_iq_pc,
	output logic [instr_w-1:0] if_iq_instr,
	output logic if_iq_valid,
	input logic if_iq_ready
);

	logic flush_q;
	logic load;
	logic [dw_sel_w-1:0] dw_sel;
	line_t src_line;

	assign dw_sel = lookup_addr[off_w-1 -: dw_sel_w];
	assign src_line = hit ? hit_line : refill_line;
	assign load = (hit | refill_en) & ~flush & ~flush_q;
	assign out_busy = if_iq_valid & ~if_iq_ready;

	always_ff @(posedge CLK) begin
		if (rst) begin
			if_iq_valid <= 1'b0;
			flush_q <= 1'b0;
		end else begin
			flush_q <= flush;
			if (flush) begin
				if_iq_valid <= 1'b0;
			end else if (load) begin
				if_iq_valid <= 1'b1;
			end else if (if_iq_ready) begin
				if_iq_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (load) begin
			if_iq_pc <= lookup_addr;
			if_iq_instr <= src_line[dw_sel*instr_w +: instr_w];
		end
	end

	a_hold_under_stall: assert property (@(posedge CLK) disable iff (rst)
		if_iq_valid && !if_iq_ready && !flush |=>
			if_iq_valid && $stable(if_iq_pc) && $stable(if_iq_instr));

endmodule

// File: hw/ifetch.sv
/*
	Instruction fetch unit, top level.
	Connects the fetch request side, the 2-way cache array, the AXI miss
	master and the output register toward the instruction queue. One
	fetch is in flight at a time; RRESP is taken but not checked.
*/

`timescale 1ns/1ps

module ifetch import ifu_pkg::*; (
	input logic CLK,
	input logic rst,

	input logic [addr_w-1:0] fetch_addr,
	output logic fetch_ready,
	input logic flush,
	input logic invalidate,

	output logic arvalid,
	input logic arready,
	output logic [addr_w-1:0] araddr,
	output logic [2:0] arprot,

	input logic rvalid,
	output logic rready,
	input line_t rdata,
	input logic [1:0] rresp, // Response code ignored

	output logic [addr_w-1:0] if_iq_pc,
	output logic [instr_w-1:0] if_iq_instr,
	output logic if_iq_valid,
	input logic if_iq_ready
);

	logic lookup_en;
	logic [addr_w-1:0] lookup_addr;
	logic hit;
	logic miss;
	line_t hit_line;
	logic refill_en;
	line_t refill_line;
	logic stale_pending;
	logic out_busy;

	fetch_req fetch_req_i (
		.CLK(CLK),
		.rst(rst),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.flush(flush),
		.out_busy(out_busy),
		.stale_pending(stale_pending),
		.done(hit | refill_en),
		.lookup_en(lookup_en),
		.lookup_addr(lookup_addr)
	);

	icache_array icache_array_i (
		.CLK(CLK),
		.rst(rst),
		.lookup_en(lookup_en),
		.lookup_addr(lookup_addr),
		.invalidate(invalidate),
		.hit(hit),
		.miss(miss),
		.hit_line(hit_line),
		.refill_en(refill_en),
		.refill_line(refill_line)
	);

	miss_axi_master miss_axi_master_i (
		.CLK(CLK),
		.rst(rst),
		.miss(miss),
		.miss_addr(lookup_addr),
		.flush(flush),
		.arvalid(arvalid),
		.araddr(araddr),
		.arprot(arprot),
		.arready(arready),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.refill_en(refill_en),
		.refill_line(refill_line),
		.stale_pending(stale_pending)
	);

	iq_out_stage iq_out_stage_i (
		.CLK(CLK),
		.rst(rst),
		.hit(hit),
		.hit_line(hit_line),
		.refill_en(refill_en),
		.refill_line(refill_line),
		.lookup_addr(lookup_addr),
		.flush(flush),
		.out_busy(out_busy),
		.if_iq_pc(if_iq_pc),
		.if_iq_instr(if_iq_instr),
		.if_iq_valid(if_iq_valid),
		.if_iq_ready(if_iq_ready)
	);

endmodule

// File: tests/tb_clock.sv
/*
	Clock and reset for the fetch unit testbench.
	40 ns clock; rst is held high for the first three rising edges.
*/

`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic rst
);

	localparam time half_period = 20ns;

	initial begin
		CLK = 1'b0;
		forever #(half_period) CLK = ~CLK;
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge CLK);
		#1 rst = 1'b0; // Released just after the third edge
	end

endmodule

// File: tests/axi_mem_model.sv
/*
	AXI read slave for the fetch unit testbench.
	Answers each AR with one 256-bit beat. Every doubleword of the line
	is a fixed pattern of its byte address. ARREADY and RVALID delays in
	cycles are set by the testbench; ar_count counts AR handshakes.
*/

`timescale 1ns/1ps

module axi_mem_model import ifu_pkg::*; (
	input logic CLK,
	input logic rst,
	input logic arvalid,
	output logic arready,
	input logic [addr_w-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output line_t rdata,
	input int ar_delay,
	input int r_delay,
	output int ar_count
);

	logic ar_v;
	logic ar_hs;
	logic r_hs;
	logic r_pend; // Beat owed for an accepted AR
	logic [addr_w-1:0] ar_a;
	int ar_wait;
	int r_wait;

	function automatic logic [instr_w-1:0] dw_pattern(input logic [addr_w-1:0] a);
		return {~(a[63:32] ^ a[31:0]), a[31:0] ^ 32'h1357_9bdf};
	endfunction

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		ar_count = 0;
		r_pend = 1'b0;
		ar_wait = 0;
		r_wait = 0;
	end

	always @(posedge CLK) begin
		ar_v = arvalid; // Sampled at the edge before the DUT updates
		ar_hs = arvalid && arready;
		r_hs = rvalid && rready;
		ar_a = araddr;
		#1;
		if (rst) begin
			arready = 1'b0;
			rvalid = 1'b0;
			r_pend = 1'b0;
			ar_wait = 0;
		end else begin
			if (r_hs) rvalid = 1'b0;
			if (ar_hs) begin
				arready = 1'b0;
				ar_count++;
				for (int d = 0; d < line_w / instr_w; d++) begin
					rdata[d*instr_w +: instr_w] = dw_pattern(ar_a + 64'(d * 8));
				end
				r_wait = r_delay;
				r_pend = 1'b1;
			end else if (ar_v && !arready) begin
				if (ar_wait >= ar_delay) begin
					arready = 1'b1;
					ar_wait = 0;
				end else begin
					ar_wait++;
				end
			end
			if (r_pend && !ar_hs) begin
				if (r_wait == 0) begin
					rvalid = 1'b1;
					r_pend = 1'b0;
				end else begin
					r_wait--;
				end
			end
		end
	end

endmodule

// File: tests/ifetch_tb.sv
/*
	Directed testbench for the instruction fetch unit.
	Each test is a task that fetches addresses and checks pc, instruction
	and AXI read counts against the memory pattern. Inputs change 1 ns
	after the rising edge, outputs are sampled at the falling edge.
	if_iq_ready is kept low between fetches so a held result blocks fetch.
*/

`timescale 1ns/1ps

module ifetch_tb import ifu_pkg::*; ();

	localparam int num_fetches = 44;
	localparam int fetch_cycles_max = 24; // Worst miss with the longest delays
	localparam int stall_cycles = 80;
	localparam int timeout_cycles = num_fetches * fetch_cycles_max + stall_cycles + 200;

	logic CLK, rst;
	logic [addr_w-1:0] fetch_addr;
	logic fetch_ready, flush, invalidate;
	logic arvalid, arready, rvalid, rready;
	logic [addr_w-1:0] araddr;
	logic [2:0] arprot;
	line_t rdata;
	logic [1:0] rresp;
	logic [addr_w-1:0] if_iq_pc;
	logic [instr_w-1:0] if_iq_instr;
	logic if_iq_valid, if_iq_ready;
	int ar_delay, r_delay, ar_count;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	int unsigned lcg_state = 82135;

	tb_clock clk_i (.CLK(CLK), .rst(rst));

	axi_mem_model mem_i (
		.CLK(CLK), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.ar_delay(ar_delay), .r_delay(r_delay), .ar_count(ar_count)
	);

	ifetch dut_i (
		.CLK(CLK), .rst(rst), .fetch_addr(fetch_addr), .fetch_ready(fetch_ready),
		.flush(flush), .invalidate(invalidate),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arprot(arprot),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.if_iq_pc(if_iq_pc), .if_iq_instr(if_iq_instr), .if_iq_valid(if_iq_valid),
		.if_iq_ready(if_iq_ready)
	);

	always @(posedge CLK) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			$display("Timeout: the run did not end within %0d cycles", timeout_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// Memory holds {~(a[63:32] ^ a[31:0]), a[31:0] ^ 13579bdf} at doubleword address a
	function automatic logic [instr_w-1:0] expected_instr(input logic [addr_w-1:0] pc);
		logic [addr_w-1:0] da;
		da = pc & ~64'h7;
		return {~(da[63:32] ^ da[31:0]), da[31:0] ^ 32'h1357_9bdf};
	endfunction

	task automatic compare_instr(input logic [instr_w-1:0] got, input logic [instr_w-1:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_pc(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// Drains the held result and waits for the edge that takes addr
	task automatic start_fetch(input logic [addr_w-1:0] addr);
		fetch_addr = addr;
		ar_delay = next_rand() % 4;
		r_delay = next_rand() % 6;
		if (flush) flush = 1'b0;
		else if_iq_ready = 1'b1;
		do @(negedge CLK); while (!fetch_ready);
		@(posedge CLK);
		#1 if_iq_ready = 1'b0;
	endtask

	// Counts edges after acceptance until if_iq_valid is seen
	task automatic wait_result(output int lat);
		lat = 0;
		do begin
			@(posedge CLK);
			lat++;
			@(negedge CLK);
		end while (!if_iq_valid);
	endtask

	task automatic check_result(input logic [addr_w-1:0] addr);
		compare_pc(if_iq_pc, addr, "if_iq_pc");
		compare_instr(if_iq_instr, expected_instr(addr), "if_iq_instr");
	endtask

	task automatic fetch_check(input logic [addr_w-1:0] addr, output int lat);
		start_fetch(addr);
		wait_result(lat);
		check_result(addr);
		@(posedge CLK);
		#1;
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - err0);
		end
	endtask

	task automatic test_cold_miss_hit();
		int n0, lat, err0;
		err0 = errors;
		n0 = ar_count;
		start_fetch(64'h1208);
		do @(negedge CLK); while (!arvalid);
		compare_pc(araddr, 64'h1200, "araddr");
		if (arprot !== 3'b001) begin
			errors++;
			$display("Mismatch at %0t: arprot got %b expected 001", $time, arprot);
		end
		wait_result(lat);
		check_result(64'h1208);
		compare_count(ar_count - n0, 1, "reads for cold miss");
		@(posedge CLK);
		#1;
		fetch_check(64'h1218, lat);
		compare_count(lat, 2, "hit latency");
		compare_count(ar_count - n0, 1, "reads after hit");
		finish_test("cold miss then hit", err0);
	endtask

	task automatic test_two_ways();
		int n0, n1, lat, err0;
		err0 = errors;
		n0 = ar_count;
		fetch_check(64'h2040, lat); // Three tags in the same set
		fetch_check(64'h2848, lat);
		compare_count(ar_count - n0, 2, "misses for two tags");
		fetch_check(64'h2058, lat);
		fetch_check(64'h2840, lat);
		compare_count(ar_count - n0, 2, "reads with both ways filled");
		fetch_check(64'h3050, lat);
		n1 = ar_count;
		fetch_check(64'h2040, lat);
		fetch_check(64'h2840, lat);
		if (ar_count == n1) report_failure("no new read after a third tag took a way");
		finish_test("two ways and replacement", err0);
	endtask

	task automatic test_back_pressure();
		int lat, err0;
		logic [addr_w-1:0] pc_h;
		logic [instr_w-1:0] instr_h;
		err0 = errors;
		start_fetch(64'h1200);
		wait_result(lat);
		check_result(64'h1200);
		pc_h = if_iq_pc;
		instr_h = if_iq_instr;
		repeat (6) begin
			@(negedge CLK);
			if (!if_iq_valid) report_failure("if_iq_valid dropped while ready was low");
			if (fetch_ready) report_failure("fetch_ready high while output was held");
			compare_pc(if_iq_pc, pc_h, "held pc");
			compare_instr(if_iq_instr, instr_h, "held instr");
		end
		@(posedge CLK);
		#1;
		fetch_check(64'h1210, lat); // Release
		finish_test("back-pressure", err0);
	endtask

	task automatic test_flush_miss();
		int n0, lat, err0;
		err0 = errors;
		n0 = ar_count;
		start_fetch(64'h5a10);
		r_delay = 6; // Keep the read out long enough to flush it
		do @(negedge CLK); while (!rready);
		@(posedge CLK);
		#1 flush = 1'b1;
		fetch_addr = 64'h6c28;
		@(posedge CLK);
		#1 flush = 1'b0;
		do begin
			@(negedge CLK);
			if (if_iq_valid) report_failure("flushed read produced an output");
			if (rready && fetch_ready) report_failure("fetch_ready high before the R beat");
		end while (rready);
		if (!fetch_ready) report_failure("fetch_ready still low after the flushed beat");
		wait_result(lat);
		check_result(64'h6c28);
		compare_count(ar_count - n0, 2, "reads for flushed and new fetch");
		@(posedge CLK);
		#1;
		finish_test("flush during miss", err0);
	endtask

	task automatic test_invalidate();
		int n0, lat, err0;
		err0 = errors;
		n0 = ar_count;
		invalidate = 1'b1;
		@(posedge CLK);
		#1 invalidate = 1'b0;
		fetch_check(64'h1208, lat);
		compare_count(ar_count - n0, 1, "reads after invalidate");
		finish_test("invalidate", err0);
	endtask

	task automatic test_random();
		int lat, err0;
		logic [addr_w-1:0] a;
		err0 = errors;
		repeat (30) begin
			a = 64'h2000; // A few tags over four sets
			a[12:11] = 2'(next_rand() % 4);
			a[6:5] = 2'(next_rand() % 4);
			a[4:3] = 2'(next_rand() % 4);
			repeat (next_rand() % 3) begin
				@(posedge CLK);
				#1;
			end
			fetch_check(a, lat);
		end
		finish_test("random sequence", err0);
	endtask

	initial begin
		fetch_addr = '0;
		flush = 1'b1; // Holds fetch off until the first test
		invalidate = 1'b0;
		if_iq_ready = 1'b0;
		rresp = 2'b00;
		ar_delay = 0;
		r_delay = 0;
		do @(posedge CLK); while (rst);
		#1;
		test_cold_miss_hit();
		test_two_ways();
		test_back_pressure();
		test_flush_miss();
		test_invalidate();
		test_random();
		$display("Tests: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: build.f
hw/ifu_pkg.sv
hw/gen_sram.sv
hw/icache_victim.sv
hw/icache_array.sv
hw/fetch_req.sv
hw/miss_axi_master.sv
hw/iq_out_stage.sv
hw/ifetch.sv
tests/tb_clock.sv
tests/axi_mem_model.sv
tests/ifetch_tb.sv
